//--- rtl/conv_loader_pkg.sv
package conv_loader_pkg;

    localparam int NUM_LANES  = 4;
    localparam int NUM_TAPS   = 3;
    localparam int NUM_STAGES = 28;

    // Stages 0..11 load weights, 12..23 load features, the rest drain.
    localparam int FEAT_BASE  = 12;
    localparam int LOAD_END   = 24;

    typedef logic [5:0]  addr_t;
    typedef logic [7:0]  data_t;
    typedef logic [4:0]  stage_t;

    // Three products of 255 by 255 still fit in 18 bits.
    typedef logic [17:0] acc_t;

    typedef logic [NUM_LANES-1:0] lane_mask_t;
    typedef logic [NUM_TAPS-1:0]  tap_sel_t;

    typedef enum logic {
        SEQ_IDLE = 1'b0,
        SEQ_RUN  = 1'b1
    } seq_state_t;

endpackage

//--- rtl/load_ctrl_if.sv
`timescale 1ns/1ps

interface load_ctrl_if;

    import conv_loader_pkg::*;

    lane_mask_t wt_en;
    lane_mask_t ft_en;
    tap_sel_t   tap_sel;
    logic       acc_clr;
    data_t      mem_data;

    // The memory read data is driven at the top level, not by the sequencer.
    modport seq (
        output wt_en,
        output ft_en,
        output tap_sel,
        output acc_clr
    );

    modport lanes (
        input wt_en,
        input ft_en,
        input tap_sel,
        input acc_clr,
        input mem_data
    );

endinterface

//--- rtl/load_sequencer.sv
`timescale 1ns/1ps

module load_sequencer (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    output conv_loader_pkg::addr_t rd_addr_o,
    output logic                   busy_o,
    output logic                   done_o,
    load_ctrl_if.seq               ctrl
);

    import conv_loader_pkg::*;

    seq_state_t state_q;
    stage_t     stage_q;
    logic       last_q;
    logic       run;

    logic       is_load;
    logic       is_feat;
    stage_t     offset;
    lane_mask_t lane_dec;
    tap_sel_t   tap_dec;

    lane_mask_t wt_en_q;
    lane_mask_t ft_en_q;
    tap_sel_t   tap_sel_q;
    logic       acc_clr_q;

    assign run = (state_q == SEQ_RUN);

    // last_q covers the cycle in which the final stage's controls are still in flight.
    assign busy_o    = run || last_q;
    assign rd_addr_o = addr_t'(stage_q);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= SEQ_IDLE;
            stage_q <= '0;
            last_q  <= 1'b0;
            done_o  <= 1'b0;
        end else begin
            done_o <= last_q;
            last_q <= 1'b0;
            case (state_q)
                SEQ_IDLE: begin
                    if (start_i && !last_q) begin
                        state_q <= SEQ_RUN;
                    end
                end
                SEQ_RUN: begin
                    if (stage_q == stage_t'(NUM_STAGES - 1)) begin
                        state_q <= SEQ_IDLE;
                        stage_q <= '0;
                        last_q  <= 1'b1;
                    end else begin
                        stage_q <= stage_q + 1'b1;
                    end
                end
                default: state_q <= SEQ_IDLE;
            endcase
        end
    end

    // Lane is the stage offset divided by the tap count, tap is the remainder.
    always_comb begin
        is_load  = run && (stage_q < stage_t'(LOAD_END));
        is_feat  = (stage_q >= stage_t'(FEAT_BASE));
        offset   = is_feat ? stage_q - stage_t'(FEAT_BASE) : stage_q;
        lane_dec = '0;
        tap_dec  = '0;
        if (is_load) begin
            lane_dec = lane_mask_t'(1) << (offset / NUM_TAPS);
            tap_dec  = tap_sel_t'(1) << (offset % NUM_TAPS);
        end
    end

    // One register stage lines the controls up with the memory read data.
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wt_en_q   <= '0;
            ft_en_q   <= '0;
            tap_sel_q <= '0;
            acc_clr_q <= 1'b0;
        end else begin
            wt_en_q   <= is_feat ? '0 : lane_dec;
            ft_en_q   <= is_feat ? lane_dec : '0;
            tap_sel_q <= tap_dec;
            acc_clr_q <= run && (stage_q == '0);
        end
    end

    assign ctrl.wt_en   = wt_en_q;
    assign ctrl.ft_en   = ft_en_q;
    assign ctrl.tap_sel = tap_sel_q;
    assign ctrl.acc_clr = acc_clr_q;

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(|ctrl.wt_en && |ctrl.ft_en))
        else $error("Weight and feature enables active together.");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(ctrl.wt_en) && $onehot0(ctrl.ft_en))
        else $error("Lane enable is not one-hot.");

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (|ctrl.wt_en || |ctrl.ft_en) |-> $onehot(ctrl.tap_sel))
        else $error("Tap select is not one-hot during a load.");

endmodule

//--- rtl/sample_mem.sv
`timescale 1ns/1ps

module sample_mem #(
    parameter int MEM_DEPTH = 64
) (
    input  logic                   clk_i,
    input  logic                   we_i,
    input  conv_loader_pkg::addr_t waddr_i,
    input  conv_loader_pkg::data_t wdata_i,
    input  conv_loader_pkg::addr_t raddr_i,
    output conv_loader_pkg::data_t rdata_o
);

    import conv_loader_pkg::*;

    data_t mem [MEM_DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Read data comes one cycle after the address.
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[raddr_i];
    end

    assert property (@(posedge clk_i) we_i |-> (int'(waddr_i) < MEM_DEPTH))
        else $error("Host write address %0d is outside the memory.", waddr_i);

endmodule

//--- rtl/mac_lanes.sv
`timescale 1ns/1ps

module mac_lanes (
    input  logic                clk_i,
    input  logic                rst_n_i,
    load_ctrl_if.lanes          ctrl,
    output conv_loader_pkg::acc_t [conv_loader_pkg::NUM_LANES-1:0] acc_o
);

    import conv_loader_pkg::*;

    data_t                      wt_q   [NUM_LANES][NUM_TAPS];
    data_t                      sel_wt [NUM_LANES];
    logic [2*$bits(data_t)-1:0] prod   [NUM_LANES];

    // A weight load writes the memory data into the selected lane and tap.
    always_ff @(posedge clk_i) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            for (int t = 0; t < NUM_TAPS; t++) begin
                if (ctrl.wt_en[l] && ctrl.tap_sel[t]) begin
                    wt_q[l][t] <= ctrl.mem_data;
                end
            end
        end
    end

    // tap_sel is one-hot, so an AND-OR picks the active weight.
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            sel_wt[l] = '0;
            for (int t = 0; t < NUM_TAPS; t++) begin
                if (ctrl.tap_sel[t]) begin
                    sel_wt[l] = sel_wt[l] | wt_q[l][t];
                end
            end
            prod[l] = sel_wt[l] * ctrl.mem_data;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            acc_o <= '0;
        end else if (ctrl.acc_clr) begin
            acc_o <= '0;
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (ctrl.ft_en[l]) begin
                    acc_o[l] <= acc_o[l] + acc_t'(prod[l]);
                end
            end
        end
    end

endmodule

//--- rtl/conv_core_top.sv
`timescale 1ns/1ps

module conv_core_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   start_i,
    input  logic                   mem_we_i,
    input  conv_loader_pkg::addr_t mem_waddr_i,
    input  conv_loader_pkg::data_t mem_wdata_i,
    output logic                   busy_o,
    output logic                   done_o,
    output conv_loader_pkg::acc_t  acc0_o,
    output conv_loader_pkg::acc_t  acc1_o,
    output conv_loader_pkg::acc_t  acc2_o,
    output conv_loader_pkg::acc_t  acc3_o
);

    import conv_loader_pkg::*;

    addr_t                  rd_addr;
    acc_t [NUM_LANES-1:0]   acc;

    load_ctrl_if ctrl_if ();

    load_sequencer load_sequencer_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (start_i),
        .rd_addr_o (rd_addr),
        .busy_o    (busy_o),
        .done_o    (done_o),
        .ctrl      (ctrl_if.seq)
    );

    // Read data goes straight onto the control interface, next to the registered enables.
    sample_mem #(
        .MEM_DEPTH (64)
    ) sample_mem_inst (
        .clk_i     (clk_i),
        .we_i      (mem_we_i),
        .waddr_i   (mem_waddr_i),
        .wdata_i   (mem_wdata_i),
        .raddr_i   (rd_addr),
        .rdata_o   (ctrl_if.mem_data)
    );

    mac_lanes mac_lanes_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .ctrl      (ctrl_if.lanes),
        .acc_o     (acc)
    );

    assign acc0_o = acc[0];
    assign acc1_o = acc[1];
    assign acc2_o = acc[2];
    assign acc3_o = acc[3];

endmodule

//--- verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

    // Reset is released on the last of the reset edges, after the flops have seen it low.
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- verif/conv_core_tb.sv
`timescale 1ns/1ps

module conv_core_tb;

    import conv_loader_pkg::*;

    localparam int SEED_INIT      = 85;
    localparam int TIMEOUT_CYCLES = 100;
    localparam int NUM_RAND_RUNS  = 6;
    localparam int MEM_WORDS      = 64;
    localparam int RUN_CYCLES     = 29;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    logic                 mem_we;
    addr_t                mem_waddr;
    data_t                mem_wdata;
    logic                 busy;
    logic                 done;
    acc_t [NUM_LANES-1:0] acc;

    data_t  mirror [MEM_WORDS];
    integer seed;
    int     errors;
    int     checks;
    int     test_num;
    int     errors_at_test_start;

    tb_clk_gen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (5)
    ) tb_clk_gen_inst (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    conv_core_top conv_core_top_inst (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .start_i     (start),
        .mem_we_i    (mem_we),
        .mem_waddr_i (mem_waddr),
        .mem_wdata_i (mem_wdata),
        .busy_o      (busy),
        .done_o      (done),
        .acc0_o      (acc[0]),
        .acc1_o      (acc[1]),
        .acc2_o      (acc[2]),
        .acc3_o      (acc[3])
    );

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else begin
            $display("FAILED at %0t: done_o stayed high for more than one cycle", $time);
            errors++;
        end

    // The end of a run is the one cycle where busy_o falls and done_o rises.
    assert property (@(posedge clk) disable iff (!rst_n) $rose(done) == $fell(busy))
        else begin
            $display("FAILED at %0t: done_o and the fall of busy_o are not aligned", $time);
            errors++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !busy |=> $stable(acc))
        else begin
            $display("FAILED at %0t: accumulator outputs changed while idle", $time);
            errors++;
        end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        assert (got === expected)
            else begin
                $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
                errors++;
            end
    endtask

    // Lane i multiplies the bytes at 3i+k with the bytes at 12+3i+k.
    function automatic int dot_product(input int lane);
        int sum;
        sum = 0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            sum += int'(mirror[NUM_TAPS*lane+k]) * int'(mirror[FEAT_BASE+NUM_TAPS*lane+k]);
        end
        return sum;
    endfunction

    task automatic check_results();
        for (int l = 0; l < NUM_LANES; l++) begin
            check_value($sformatf("acc%0d_o", l), acc[l], dot_product(l));
        end
    endtask

    task automatic fill_pattern();
        for (int a = 0; a < MEM_WORDS; a++) begin
            if (a < FEAT_BASE) begin
                mirror[a] = data_t'(a + 1);
            end else if (a < LOAD_END) begin
                mirror[a] = data_t'(a - FEAT_BASE + 2);
            end else begin
                mirror[a] = data_t'(a) ^ 8'hA5;
            end
        end
    endtask

    task automatic fill_random(input bit near_top);
        for (int a = 0; a < MEM_WORDS; a++) begin
            mirror[a] = data_t'($random(seed));
            if (near_top) begin
                mirror[a] = mirror[a] | 8'hF8;
            end
        end
    endtask

    task automatic load_memory();
        for (int a = 0; a < MEM_WORDS; a++) begin
            @(posedge clk);
            mem_we    <= 1'b1;
            mem_waddr <= addr_t'(a);
            mem_wdata <= mirror[a];
        end
        @(posedge clk);
        mem_we <= 1'b0;
    endtask

    // Mode 0 pulses start once, mode 1 holds it through the run, mode 2 pulses it again.
    task automatic run_core(input int mode);
        int cycles;
        int busy_cycles;
        bit seen_done;
        cycles      = 0;
        busy_cycles = 0;
        seen_done   = 1'b0;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= (mode == 1);
        while (!seen_done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (done) begin
                seen_done = 1'b1;
            end else begin
                if (busy) begin
                    busy_cycles++;
                end
                @(posedge clk);
                cycles++;
                start <= (mode == 1 && cycles < RUN_CYCLES) ||
                         (mode == 2 && (cycles == 10 || cycles == RUN_CYCLES - 1));
            end
        end
        if (!seen_done) begin
            $display("Timeout: done_o did not pulse within %0d cycles of the start",
                     TIMEOUT_CYCLES);
            errors++;
        end else begin
            check_value("cycles from start to done_o", cycles, RUN_CYCLES);
            check_value("cycles with busy_o high", busy_cycles, RUN_CYCLES);
            check_value("busy_o together with done_o", busy, 1'b0);
        end
    endtask

    task automatic idle_check(input int num_cycles);
        repeat (num_cycles) begin
            @(negedge clk);
            check_value("done_o while idle", done, 1'b0);
            check_value("busy_o while idle", busy, 1'b0);
        end
    endtask

    task automatic begin_test();
        test_num++;
        errors_at_test_start = errors;
    endtask

    task automatic end_test(input string name);
        $display("Test %0d %s finished with %0d errors", test_num, name,
                 errors - errors_at_test_start);
    endtask

    initial begin
        int n;
        start     = 1'b0;
        mem_we    = 1'b0;
        mem_waddr = '0;
        mem_wdata = '0;
        seed      = SEED_INIT;
        errors    = 0;
        checks    = 0;
        test_num  = 0;
        n         = 0;
        while (!rst_n && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!rst_n) begin
            $display("Timeout: reset was never released");
            errors++;
        end

        begin_test();
        @(negedge clk);
        check_value("busy_o after reset", busy, 1'b0);
        check_value("done_o after reset", done, 1'b0);
        for (int l = 0; l < NUM_LANES; l++) begin
            check_value($sformatf("acc%0d_o after reset", l), acc[l], 0);
        end
        end_test("reset values");

        begin_test();
        fill_pattern();
        load_memory();
        run_core(0);
        check_results();
        end_test("fixed pattern");

        begin_test();
        idle_check(8);
        check_results();
        end_test("results held while idle");

        begin_test();
        run_core(1);
        check_results();
        idle_check(4);
        run_core(2);
        check_results();
        idle_check(4);
        end_test("start while busy");

        begin_test();
        fill_random(1'b0);
        load_memory();
        run_core(0);
        check_results();
        end_test("fresh results on new contents");

        begin_test();
        for (int r = 0; r < NUM_RAND_RUNS; r++) begin
            fill_random(r % 2 == 0);
            load_memory();
            run_core(0);
            check_results();
        end
        end_test("random contents");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_num, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/conv_loader_pkg.sv
rtl/load_ctrl_if.sv
rtl/load_sequencer.sv
rtl/sample_mem.sv
rtl/mac_lanes.sv
rtl/conv_core_top.sv
verif/tb_clk_gen.sv
verif/conv_core_tb.sv

//--- Bender.yml
package:
  name: conv_core

sources:
  - files:
      - rtl/conv_loader_pkg.sv
      - rtl/load_ctrl_if.sv
      - rtl/load_sequencer.sv
      - rtl/sample_mem.sv
      - rtl/mac_lanes.sv
      - rtl/conv_core_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/conv_core_tb.sv
